// ==== design/err_det_pkg.sv ====
package err_det_pkg;

    // default number of module pairs per channel.
    localparam int NUM_PAIRS = 4;

    // one-hot module pair select.
    typedef logic [NUM_PAIRS-1:0] pair_sel_t;

    // sense lines of one channel, bit 2p is X and bit 2p+1 is Y of pair p.
    typedef logic [2*NUM_PAIRS-1:0] sense_t;

    // access kind of one channel, never both set.
    typedef struct packed {
        logic dm;       // data access.
        logic im;       // instruction access.
    } access_t;

    // timing strobes, one clock wide each.
    typedef struct packed {
        logic cycle_start;  // start of memory cycle.
        logic check;        // parity and sense sampling point.
        logic w3;
        logic v4;
        logic recover;
    } strobes_t;

    // status reported by one channel.
    typedef struct packed {
        logic par_err_dm;
        logic par_err_im;
        logic corr_dm;
        logic corr_im;
        logic fail_sw;      // sense disagreement on selected pair.
        logic branch;
        logic chan_err;     // combinational.
    } chan_status_t;

endpackage

// ==== design/parity_error_latch.sv ====
`timescale 1ns/1ns

module parity_error_latch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  err_det_pkg::strobes_t strb,
    input  logic                  active,
    input  logic                  par_ok,
    input  logic                  mismatch,
    output logic                  par_err,
    output logic                  corr
);

    logic par_err_q;
    logic corr_q;

    // parity error latch.
    // a bad check is ignored once the correction flag is up.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            par_err_q <= 1'b0;
        end else if (strb.recover) begin
            par_err_q <= 1'b0;
        end else if (strb.check && active) begin
            if (!par_ok && !corr_q) begin
                par_err_q <= 1'b1;
            end else if (par_ok) begin
                par_err_q <= 1'b0;  // good parity clears.
            end
        end
    end

    // correction flag, set when the expected outcome contradicts the switch.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            corr_q <= 1'b0;
        end else if (strb.recover) begin
            corr_q <= 1'b0;
        end else if (strb.w3 && active && mismatch) begin
            corr_q <= 1'b1;
        end
    end

    assign par_err = par_err_q;
    assign corr    = corr_q;

endmodule

// ==== design/sense_disagree_det.sv ====
`timescale 1ns/1ns

module sense_disagree_det #(
    parameter int NUM_PAIRS = err_det_pkg::NUM_PAIRS
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  err_det_pkg::strobes_t  strb,
    input  logic                   any_access,
    input  err_det_pkg::pair_sel_t pair_sel,
    input  err_det_pkg::sense_t    sense,
    output logic                   fail_sw
);

    logic coincide;
    logic fail_sw_q;

    // X and Y both set on any selected pair.
    always_comb begin
        coincide = 1'b0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            coincide = coincide | (pair_sel[p] & sense[2*p] & sense[2*p+1]);
        end
    end

    // lives for one memory cycle; set wins over clear.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fail_sw_q <= 1'b0;
        end else if (strb.check && any_access && coincide) begin
            fail_sw_q <= 1'b1;
        end else if (strb.cycle_start) begin
            fail_sw_q <= 1'b0;
        end
    end

    assign fail_sw = fail_sw_q;

endmodule

// ==== design/channel_error_ctl.sv ====
`timescale 1ns/1ns

module channel_error_ctl #(
    parameter int NUM_PAIRS = err_det_pkg::NUM_PAIRS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  err_det_pkg::strobes_t     strb,
    input  err_det_pkg::access_t      acc,
    input  logic                      par_ok,
    input  err_det_pkg::sense_t       sense,
    input  err_det_pkg::pair_sel_t    pair_sel,
    input  logic                      exp_fail,
    output err_det_pkg::chan_status_t status
);

    logic any_access;
    logic fail_sw;
    logic mismatch;
    logic par_err_dm;
    logic par_err_im;
    logic corr_dm;
    logic corr_im;
    logic err_hit;
    logic branch_q;

    assign any_access = acc.dm | acc.im;
    assign mismatch   = exp_fail ^ fail_sw;  // comparison outcome vs. switch.

    parity_error_latch i_latch_dm (
        .clk      (clk),
        .rst_n    (rst_n),
        .strb     (strb),
        .active   (acc.dm),
        .par_ok   (par_ok),
        .mismatch (mismatch),
        .par_err  (par_err_dm),
        .corr     (corr_dm)
    );

    parity_error_latch i_latch_im (
        .clk      (clk),
        .rst_n    (rst_n),
        .strb     (strb),
        .active   (acc.im),
        .par_ok   (par_ok),
        .mismatch (mismatch),
        .par_err  (par_err_im),
        .corr     (corr_im)
    );

    sense_disagree_det #(
        .NUM_PAIRS (NUM_PAIRS)
    ) i_sense_det (
        .clk        (clk),
        .rst_n      (rst_n),
        .strb       (strb),
        .any_access (any_access),
        .pair_sel   (pair_sel),
        .sense      (sense),
        .fail_sw    (fail_sw)
    );

    // error on the kind that is currently accessing.
    assign err_hit = (acc.dm & par_err_dm) | (acc.im & par_err_im);

    // branch after an erroneous access, dropped again at v4.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            branch_q <= 1'b0;
        end else if (strb.w3 && err_hit) begin
            branch_q <= 1'b1;
        end else if (strb.v4) begin
            branch_q <= 1'b0;
        end
    end

    always_comb begin
        status.par_err_dm = par_err_dm;
        status.par_err_im = par_err_im;
        status.corr_dm    = corr_dm;
        status.corr_im    = corr_im;
        status.fail_sw    = fail_sw;
        status.branch     = branch_q;
        status.chan_err   = (acc.dm & corr_dm) | (acc.im & corr_im);  // no latency.
    end

endmodule

// ==== design/module_sync_gen.sv ====
`timescale 1ns/1ns

module module_sync_gen #(
    parameter int NUM_PAIRS = err_det_pkg::NUM_PAIRS
) (
    input  logic                   v4,
    input  logic                   sync_req,
    input  err_det_pkg::pair_sel_t pair_sel,
    input  err_det_pkg::access_t   acc_a,
    input  err_det_pkg::access_t   acc_b,
    output logic [2*NUM_PAIRS-1:0] m_sync
);

    logic idle_a;
    logic idle_b;

    assign idle_a = ~(acc_a.dm | acc_a.im);
    assign idle_b = ~(acc_b.dm | acc_b.im);

    // even index is channel A, odd index is channel B.
    always_comb begin
        for (int p = 0; p < NUM_PAIRS; p++) begin
            m_sync[2*p]   = v4 & (idle_a | sync_req | pair_sel[p]);
            m_sync[2*p+1] = v4 & (idle_b | sync_req | pair_sel[p]);
        end
    end

endmodule

// ==== design/error_det_sw.sv ====
`timescale 1ns/1ns

module error_det_sw #(
    parameter int NUM_PAIRS = err_det_pkg::NUM_PAIRS
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  err_det_pkg::strobes_t     strb,
    input  err_det_pkg::access_t      acc_a,
    input  err_det_pkg::access_t      acc_b,
    input  logic                      par_ok_a,
    input  logic                      par_ok_b,
    input  err_det_pkg::sense_t       sense_a,
    input  err_det_pkg::sense_t       sense_b,
    input  err_det_pkg::pair_sel_t    pair_sel,
    input  logic                      sync_req,
    input  logic                      exp_fail,
    output err_det_pkg::chan_status_t status_a,
    output err_det_pkg::chan_status_t status_b,
    output logic [2*NUM_PAIRS-1:0]    m_sync
);

    channel_error_ctl #(
        .NUM_PAIRS (NUM_PAIRS)
    ) i_chan_a (
        .clk      (clk),
        .rst_n    (rst_n),
        .strb     (strb),
        .acc      (acc_a),
        .par_ok   (par_ok_a),
        .sense    (sense_a),
        .pair_sel (pair_sel),
        .exp_fail (exp_fail),
        .status   (status_a)
    );

    channel_error_ctl #(
        .NUM_PAIRS (NUM_PAIRS)
    ) i_chan_b (
        .clk      (clk),
        .rst_n    (rst_n),
        .strb     (strb),
        .acc      (acc_b),
        .par_ok   (par_ok_b),
        .sense    (sense_b),
        .pair_sel (pair_sel),
        .exp_fail (exp_fail),
        .status   (status_b)
    );

    // sync levels for all modules of both channels.
    module_sync_gen #(
        .NUM_PAIRS (NUM_PAIRS)
    ) i_sync_gen (
        .v4       (strb.v4),
        .sync_req (sync_req),
        .pair_sel (pair_sel),
        .acc_a    (acc_a),
        .acc_b    (acc_b),
        .m_sync   (m_sync)
    );

endmodule

// ==== bench/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

// ==== bench/tb_error_det_sw.sv ====
`timescale 1ns/1ns

module tb_error_det_sw;

    import err_det_pkg::*;

    localparam int NUM_PAIRS       = err_det_pkg::NUM_PAIRS;
    localparam int RANDOM_CYCLES   = 1500;
    localparam int SCRIPTED_CYCLES = 2000;                // directed part plus random part.
    localparam int TIMEOUT_CYCLES  = 2 * SCRIPTED_CYCLES;

    localparam strobes_t NONE      = 5'b00000;
    localparam strobes_t CYCLE_S   = 5'b10000;
    localparam strobes_t CHECK_S   = 5'b01000;
    localparam strobes_t W3_S      = 5'b00100;
    localparam strobes_t V4_S      = 5'b00010;
    localparam strobes_t RECOVER_S = 5'b00001;

    localparam access_t IDLE = 2'b00;
    localparam access_t DM   = 2'b10;
    localparam access_t IM   = 2'b01;

    logic                   clk;
    logic                   rst_n;
    strobes_t               strb;
    access_t                acc_a;
    access_t                acc_b;
    logic                   par_ok_a;
    logic                   par_ok_b;
    sense_t                 sense_a;
    sense_t                 sense_b;
    pair_sel_t              pair_sel;
    logic                   sync_req;
    logic                   exp_fail;
    chan_status_t           status_a;
    chan_status_t           status_b;
    logic [2*NUM_PAIRS-1:0] m_sync;

    chan_status_t           mdl_a;    // registered flags of the reference model.
    chan_status_t           mdl_b;
    chan_status_t           exp_a;
    chan_status_t           exp_b;
    logic [2*NUM_PAIRS-1:0] exp_sync;
    logic [31:0]            lfsr_state;
    int                     error_count;
    int                     cycle_count;
    string                  test_name;
    strobes_t               rnd_strb;

    tb_clock #(
        .PERIOD (100)
    ) i_tb_clock (
        .clk (clk)
    );

    error_det_sw #(
        .NUM_PAIRS (NUM_PAIRS)
    ) i_error_det_sw (
        .clk      (clk),
        .rst_n    (rst_n),
        .strb     (strb),
        .acc_a    (acc_a),
        .acc_b    (acc_b),
        .par_ok_a (par_ok_a),
        .par_ok_b (par_ok_b),
        .sense_a  (sense_a),
        .sense_b  (sense_b),
        .pair_sel (pair_sel),
        .sync_req (sync_req),
        .exp_fail (exp_fail),
        .status_a (status_a),
        .status_b (status_b),
        .m_sync   (m_sync)
    );

    // galois lfsr, one step per bit taken.
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // flags of one channel after a clock edge with the current inputs.
    function automatic chan_status_t next_status(input chan_status_t st, input access_t acc,
                                                 input logic par_ok, input sense_t sense,
                                                 input strobes_t s, input pair_sel_t sel,
                                                 input logic exp_f);
        chan_status_t nx;
        logic         hit;
        nx  = st;
        hit = 1'b0;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            hit = hit | (sel[p] & sense[2*p] & sense[2*p+1]);
        end
        if (s.recover) begin
            nx.par_err_dm = 1'b0;
            nx.par_err_im = 1'b0;
            nx.corr_dm    = 1'b0;
            nx.corr_im    = 1'b0;
        end else begin
            // bad parity holds the flag while corr is up.
            if (s.check && acc.dm) begin
                nx.par_err_dm = par_ok ? 1'b0 : (st.par_err_dm | ~st.corr_dm);
            end
            if (s.check && acc.im) begin
                nx.par_err_im = par_ok ? 1'b0 : (st.par_err_im | ~st.corr_im);
            end
            if (s.w3 && acc.dm && (exp_f != st.fail_sw)) begin
                nx.corr_dm = 1'b1;
            end
            if (s.w3 && acc.im && (exp_f != st.fail_sw)) begin
                nx.corr_im = 1'b1;
            end
        end
        if (s.check && (acc.dm || acc.im) && hit) begin
            nx.fail_sw = 1'b1;
        end else if (s.cycle_start) begin
            nx.fail_sw = 1'b0;
        end
        if (s.w3 && ((acc.dm && st.par_err_dm) || (acc.im && st.par_err_im))) begin
            nx.branch = 1'b1;
        end else if (s.v4) begin
            nx.branch = 1'b0;
        end
        nx.chan_err = 1'b0;
        return nx;
    endfunction

    function automatic logic [2*NUM_PAIRS-1:0] expect_sync(input logic v4, input logic req,
                                                           input pair_sel_t sel,
                                                           input access_t a, input access_t b);
        logic [2*NUM_PAIRS-1:0] m;
        for (int p = 0; p < NUM_PAIRS; p++) begin
            m[2*p]   = v4 && (!(a.dm || a.im) || req || sel[p]);
            m[2*p+1] = v4 && (!(b.dm || b.im) || req || sel[p]);
        end
        return m;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdl_a <= '0;
            mdl_b <= '0;
        end else begin
            mdl_a <= next_status(mdl_a, acc_a, par_ok_a, sense_a, strb, pair_sel, exp_fail);
            mdl_b <= next_status(mdl_b, acc_b, par_ok_b, sense_b, strb, pair_sel, exp_fail);
        end
    end

    always_comb begin
        exp_a          = mdl_a;
        exp_a.chan_err = (acc_a.dm & mdl_a.corr_dm) | (acc_a.im & mdl_a.corr_im);
        exp_b          = mdl_b;
        exp_b.chan_err = (acc_b.dm & mdl_b.corr_dm) | (acc_b.im & mdl_b.corr_im);
        exp_sync       = expect_sync(strb.v4, sync_req, pair_sel, acc_a, acc_b);
    end

    task automatic note_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] act);
        error_count++;
        $display("[FAIL] %s %s: expected %h, actual %h", test_name, what, exp, act);
    endtask

    chk_status_a: assert property (@(posedge clk) disable iff (!rst_n) status_a == exp_a)
        else note_mismatch("status_a", 32'($sampled(exp_a)), 32'($sampled(status_a)));
    chk_status_b: assert property (@(posedge clk) disable iff (!rst_n) status_b == exp_b)
        else note_mismatch("status_b", 32'($sampled(exp_b)), 32'($sampled(status_b)));
    chk_m_sync: assert property (@(posedge clk) disable iff (!rst_n) m_sync == exp_sync)
        else note_mismatch("m_sync", 32'($sampled(exp_sync)), 32'($sampled(m_sync)));

    // strobe goes out on this falling edge and drops on the next.
    task automatic run_cycle(input strobes_t s);
        strb = s;
        @(negedge clk);
        strb = NONE;
    endtask

    task automatic randomize_inputs(output strobes_t s);
        logic [31:0] r;
        int          pick;
        r        = take_bits(8);
        acc_a    = access_t'(r[1:0]);
        acc_b    = access_t'(r[3:2]);
        par_ok_a = r[4];
        par_ok_b = r[5];
        sync_req = r[6];
        exp_fail = r[7];
        if (acc_a.dm && acc_a.im) begin
            acc_a = IDLE;  // both kinds at once never occurs.
        end
        if (acc_b.dm && acc_b.im) begin
            acc_b = IDLE;
        end
        sense_a  = sense_t'(take_bits(2 * NUM_PAIRS));
        sense_b  = sense_t'(take_bits(2 * NUM_PAIRS));
        pick     = int'(take_bits(8)) % NUM_PAIRS;
        pair_sel = pair_sel_t'(1) << pick;
        pick     = int'(take_bits(3));
        s        = (pick < 5) ? strobes_t'(5'b1 << pick) : NONE;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        strb        = NONE;
        acc_a       = IDLE;
        acc_b       = IDLE;
        par_ok_a    = 1'b1;
        par_ok_b    = 1'b1;
        sense_a     = '0;
        sense_b     = '0;
        pair_sel    = pair_sel_t'(1);
        sync_req    = 1'b0;
        exp_fail    = 1'b0;
        lfsr_state  = 32'h9636;
        error_count = 0;
        rnd_strb    = NONE;
        test_name   = "reset";
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        run_cycle(NONE);
        run_cycle(V4_S);

        test_name = "parity";
        for (int k = 0; k < 2; k++) begin
            acc_a    = (k == 0) ? DM : IM;
            acc_b    = acc_a;
            par_ok_a = 1'b0;
            par_ok_b = 1'b0;
            run_cycle(CHECK_S);
            run_cycle(NONE);
            par_ok_a = 1'b1;
            par_ok_b = 1'b1;
            run_cycle(CHECK_S);   // good check clears.
            par_ok_a = 1'b0;
            par_ok_b = 1'b0;
            run_cycle(CHECK_S);
            run_cycle(RECOVER_S);
        end

        test_name = "fail_switch";
        acc_a    = DM;
        acc_b    = IM;
        par_ok_a = 1'b1;
        par_ok_b = 1'b1;
        pair_sel = pair_sel_t'(2);
        sense_a  = sense_t'(4'b1100);  // pair 1, selected.
        sense_b  = sense_t'(2'b11);    // pair 0, not selected.
        run_cycle(CHECK_S);
        run_cycle(NONE);
        run_cycle(CYCLE_S);

        test_name = "correction";
        sense_a  = '0;
        sense_b  = '0;
        exp_fail = 1'b1;
        acc_b    = IDLE;
        run_cycle(W3_S);
        acc_a = IM;
        run_cycle(NONE);
        acc_a    = DM;
        par_ok_a = 1'b0;
        run_cycle(CHECK_S);
        run_cycle(RECOVER_S);
        exp_fail = 1'b0;

        test_name = "branch";
        run_cycle(CHECK_S);
        run_cycle(W3_S);
        run_cycle(V4_S);
        acc_a    = IDLE;
        par_ok_a = 1'b1;
        acc_b    = IM;
        par_ok_b = 1'b0;
        run_cycle(CHECK_S);
        run_cycle(W3_S);
        run_cycle(V4_S);
        run_cycle(RECOVER_S);

        test_name = "random";
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            randomize_inputs(rnd_strb);
            run_cycle(rnd_strb);
        end

        $display("run complete, %0d errors", error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== error_det_sw.f ====
design/err_det_pkg.sv
design/parity_error_latch.sv
design/sense_disagree_det.sv
design/channel_error_ctl.sv
design/module_sync_gen.sv
design/error_det_sw.sv
bench/tb_clock.sv
bench/tb_error_det_sw.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --timescale 1ns/1ns \
    --top-module tb_error_det_sw \
    -f error_det_sw.f \
    -o sim_error_det_sw

./obj_dir/sim_error_det_sw | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
